/* rtl/photon_pkg.sv */
package photon_pkg;

    ////////////////////
    // count geometry.
    localparam int count_digits = 8;

    typedef logic [3:0]                      bcd_digit_t;   // one decimal digit.
    typedef logic [4*count_digits-1:0]       count_bcd_t;   // lsd in low nibble.
    typedef logic [$clog2(count_digits)-1:0] digit_idx_t;

    ////////////////////
    // quench and recharge timing.
    localparam int quench_cycles   = 4;
    localparam int recharge_cycles = 3;
    localparam int phase_w         = $clog2(quench_cycles > recharge_cycles ?
                                            quench_cycles : recharge_cycles);

    typedef logic [phase_w-1:0] phase_cnt_t;

    typedef enum logic [1:0] {
        st_armed,       // waiting for a detector edge.
        st_quench,      // bias pulled down.
        st_recharge     // parasitic capacitance discharged.
    } quench_state_t;

    // push button filter.
    localparam int debounce_cycles = 16;

    typedef logic [$clog2(debounce_cycles)-1:0] debounce_cnt_t;

    ////////////////////
    // serial report.
    localparam int baud_div      = 8;                 // clocks per bit.
    localparam int report_cycles = 1024;              // snapshot interval.
    localparam int frame_bytes   = count_digits + 2;  // digits, cr, lf.

    typedef logic [7:0]                        ascii_t;
    typedef logic [$clog2(baud_div)-1:0]       baud_cnt_t;
    typedef logic [$clog2($bits(ascii_t))-1:0] bit_idx_t;
    typedef logic [$clog2(frame_bytes)-1:0]    frame_idx_t;
    typedef logic [$clog2(report_cycles)-1:0]  report_cnt_t;

    localparam ascii_t ascii_zero = 8'h30;
    localparam ascii_t ascii_cr   = 8'h0d;
    localparam ascii_t ascii_lf   = 8'h0a;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_t;

endpackage

/* rtl/pulse_quench_ctrl.sv */
`timescale 1ns/10ps

module pulse_quench_ctrl
    import photon_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic signal_pulse,      // raw detector output.
    output logic detect,            // one strobe per accepted pulse.
    output logic geiger_mode_en,    // low during the whole dead time.
    output logic quench,            // pulls the diode bias down.
    output logic recharge           // discharges the parasitic capacitance.
);

    logic          sync_1;
    logic          sync_2;
    logic          sync_3;          // previous synchronized level.
    logic          rise_q;          // registered rising edge.
    logic          accept;
    quench_state_t state;
    quench_state_t state_nx;
    phase_cnt_t    phase;
    phase_cnt_t    phase_nx;

    ////////////////////
    // synchronizer and edge detect.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            sync_3 <= 1'b0;
            rise_q <= 1'b0;
        end
        else
        begin
            sync_1 <= signal_pulse;
            sync_2 <= sync_1;
            sync_3 <= sync_2;
            rise_q <= sync_2 & ~sync_3;     // a held level gives one edge only.
        end
    end

    assign accept = (state == st_armed) && rise_q;  // edges in dead time are dropped.

    ////////////////////
    // dead time fsm.
    always_comb
    begin
        state_nx = state;
        phase_nx = phase;
        unique case (state)
            st_armed:
            begin
                if (rise_q)
                begin
                    state_nx = st_quench;
                    phase_nx = '0;
                end
            end
            st_quench:
            begin
                if (phase == phase_cnt_t'(quench_cycles - 1))
                begin
                    state_nx = st_recharge;
                    phase_nx = '0;
                end
                else
                    phase_nx = phase + 1'b1;
            end
            st_recharge:
            begin
                if (phase == phase_cnt_t'(recharge_cycles - 1))
                begin
                    state_nx = st_armed;    // re-arm.
                    phase_nx = '0;
                end
                else
                    phase_nx = phase + 1'b1;
            end
            default: state_nx = st_armed;
        endcase
    end

    // outputs follow the next state so they line up with it.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state          <= st_armed;
            phase          <= '0;
            detect         <= 1'b0;
            geiger_mode_en <= 1'b1;
            quench         <= 1'b0;
            recharge       <= 1'b0;
        end
        else
        begin
            state          <= state_nx;
            phase          <= phase_nx;
            detect         <= accept;
            geiger_mode_en <= (state_nx == st_armed);
            quench         <= (state_nx == st_quench);
            recharge       <= (state_nx == st_recharge);
        end
    end

    // quench holds its full length, then hands over to recharge.
    a_quench_handover: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(quench) |-> recharge && !$past(recharge)
                          && $past(quench, quench_cycles)
                          && !$past(quench, quench_cycles + 1));

    // a count only comes from armed and starts the quench at once.
    a_detect_armed: assert property (@(posedge clk) disable iff (!rst_n)
        detect |-> $past(geiger_mode_en) && quench && !geiger_mode_en);

endmodule

/* rtl/bcd_event_counter.sv */
`timescale 1ns/10ps

module bcd_event_counter
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       detect,  // accepted photon.
    input  logic       clear,   // button press.
    output count_bcd_t count
);

    count_bcd_t count_inc;
    bcd_digit_t digit;
    logic       carry;

    ////////////////////
    // ripple carry increment.
    always_comb
    begin
        count_inc = count;
        carry     = 1'b1;                   // add one at the lsd.
        digit     = '0;
        for (int i = 0; i < count_digits; i++)
        begin
            digit = count[4*i +: 4];
            if (carry)
            begin
                if (digit == bcd_digit_t'(9))
                    digit = '0;             // roll over, carry stays.
                else
                begin
                    digit = digit + 1'b1;
                    carry = 1'b0;
                end
            end
            count_inc[4*i +: 4] = digit;
        end
    end

    // top digit wraps to all zero.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            count <= '0;
        else if (clear)
            count <= '0;                    // clear beats detect.
        else if (detect)
            count <= count_inc;
    end

    ////////////////////
    // every digit stays decimal.
    for (genvar g = 0; g < count_digits; g++)
    begin : g_digit_chk
        a_digit_range: assert property (@(posedge clk) disable iff (!rst_n)
            count[4*g +: 4] <= bcd_digit_t'(9));
    end

endmodule

/* rtl/key_debounce.sv */
`timescale 1ns/10ps

module key_debounce
    import photon_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic key_pin,   // active low button.
    output logic pressed,   // debounced level.
    output logic key_down   // strobe on press.
);

    logic          key_s1;
    logic          key_s2;  // synchronized, active high.
    debounce_cnt_t stable_cnt;

    ////////////////////
    // sync and invert.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            key_s1 <= 1'b0;             // released.
            key_s2 <= 1'b0;
        end
        else
        begin
            key_s1 <= ~key_pin;
            key_s2 <= key_s1;
        end
    end

    ////////////////////
    // stability filter.
    // the sampled level only has two values, so a change back
    // to the accepted level is what restarts the count.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            stable_cnt <= '0;
            pressed    <= 1'b0;
            key_down   <= 1'b0;
        end
        else
        begin
            key_down <= 1'b0;
            if (key_s2 == pressed)
                stable_cnt <= '0;                   // bounce or idle.
            else if (stable_cnt == debounce_cnt_t'(debounce_cycles - 1))
            begin
                stable_cnt <= '0;
                pressed    <= key_s2;               // new level accepted.
                key_down   <= key_s2;               // only on press.
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // the strobe needs the pressed level held for the whole filter time.
    a_down_after_hold: assert property (@(posedge clk) disable iff (!rst_n)
        key_down |-> pressed && $past(key_s2, debounce_cycles)
                     && !$past(key_s2, debounce_cycles + 1));

endmodule

/* rtl/uart_count_report.sv */
`timescale 1ns/10ps

module uart_count_report
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  count_bcd_t count,
    output logic       tx       // idles high.
);

    report_cnt_t interval;
    logic        snap_tick;
    count_bcd_t  snap;          // frozen count for one frame.
    tx_state_t   state;
    baud_cnt_t   baud;
    logic        bit_end;
    bit_idx_t    bit_idx;
    frame_idx_t  byte_idx;
    ascii_t      shift;
    ascii_t      tx_byte;
    digit_idx_t  digit_pos;
    bcd_digit_t  digit;

    ////////////////////
    // report interval.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            interval <= '0;
        else if (snap_tick)
            interval <= '0;
        else
            interval <= interval + 1'b1;
    end

    assign snap_tick = (interval == report_cnt_t'(report_cycles - 1));

    // byte select. msd goes first.
    always_comb
    begin
        digit_pos = digit_idx_t'(count_digits - 1) - digit_idx_t'(byte_idx);
        digit     = snap[{digit_pos, 2'b00} +: 4];
        if (byte_idx < frame_idx_t'(count_digits))
            tx_byte = ascii_zero + ascii_t'(digit);
        else if (byte_idx == frame_idx_t'(count_digits))
            tx_byte = ascii_cr;
        else
            tx_byte = ascii_lf;
    end

    assign bit_end = (baud == baud_cnt_t'(baud_div - 1));

    ////////////////////
    // transmit fsm.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= tx_idle;
            baud     <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            tx       <= 1'b1;
        end
        else
        begin
            if (state == tx_idle || bit_end)
                baud <= '0;
            else
                baud <= baud + 1'b1;

            unique case (state)
                tx_idle:
                begin
                    if (snap_tick)
                    begin
                        byte_idx <= '0;
                        state    <= tx_start;
                        tx       <= 1'b0;           // first start bit.
                    end
                end
                tx_start:
                begin
                    if (bit_end)
                    begin
                        bit_idx <= '0;
                        state   <= tx_data;
                        tx      <= tx_byte[0];      // lsb first.
                    end
                end
                tx_data:
                begin
                    if (bit_end)
                    begin
                        if (bit_idx == bit_idx_t'($bits(ascii_t) - 1))
                        begin
                            state <= tx_stop;
                            tx    <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift[1];
                        end
                    end
                end
                tx_stop:
                begin
                    if (bit_end)
                    begin
                        if (byte_idx == frame_idx_t'(frame_bytes - 1))
                            state <= tx_idle;       // frame done, line stays high.
                        else
                        begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= tx_start;
                            tx       <= 1'b0;
                        end
                    end
                end
                default: state <= tx_idle;
            endcase
        end
    end

    // payload path.
    always_ff @(posedge clk)
    begin
        if (state == tx_idle && snap_tick)
            snap <= count;
        if (state == tx_start && bit_end)
            shift <= tx_byte;
        else if (state == tx_data && bit_end)
            shift <= {1'b1, shift[7:1]};
    end

    // the interval always covers a full frame.
    a_snap_idle: assert property (@(posedge clk) disable iff (!rst_n)
        snap_tick |-> state == tx_idle);

endmodule

/* rtl/photon_counter_top.sv */
`timescale 1ns/10ps

module photon_counter_top
    import photon_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic signal_pulse,          // detector output.
    input  logic key_pin,               // active low button.
    output logic geiger_mode_en,
    output logic quench_voltage_down,
    output logic reset_discharge,
    output logic led,                   // lit while the button is held.
    output logic tx_pin                 // count report.
);

    logic       detect;
    logic       key_down;
    count_bcd_t count;

    ////////////////////
    // front end.
    pulse_quench_ctrl u_quench (
        .clk            (clk),
        .rst_n          (rst_n),
        .signal_pulse   (signal_pulse),
        .detect         (detect),
        .geiger_mode_en (geiger_mode_en),
        .quench         (quench_voltage_down),
        .recharge       (reset_discharge)
    );

    bcd_event_counter u_counter (
        .clk    (clk),
        .rst_n  (rst_n),
        .detect (detect),
        .clear  (key_down),             // press clears the count.
        .count  (count)
    );

    ////////////////////
    // user side.
    key_debounce u_key (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_pin  (key_pin),
        .pressed  (led),
        .key_down (key_down)
    );

    uart_count_report u_report (
        .clk   (clk),
        .rst_n (rst_n),
        .count (count),
        .tx    (tx_pin)
    );

endmodule

/* tb/photon_checker.sv */
`timescale 1ns/10ps

module photon_checker
    import photon_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic signal_pulse,
    input logic geiger_mode_en,
    input logic quench_voltage_down,
    input logic reset_discharge,
    input logic led,
    input logic tx_pin
);

    localparam int dead_cycles = quench_cycles + recharge_cycles;

    int unsigned error_count     = 0;
    int unsigned errors_at_start = 0;
    int unsigned tests_run       = 0;
    int unsigned tests_failed    = 0;
    int unsigned frames_seen     = 0;
    int unsigned frames_at_start = 0;
    int unsigned events          = 0;   // dead times in this phase.
    int          sample_cnt      = 0;   // falling edges since reset.
    count_bcd_t  last_frame      = '0;  // newest complete frame.
    logic [4:0]  pulse_hist      = '0;  // detector samples, newest in bit 0.

    ////////////////////
    // reporting.
    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("[ERROR] %s: got %h expected %h", name, got, exp);
        error_count++;
    endtask

    task automatic plain_error(input string what);
        $display("%0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            value_error(name, 32'(got), 32'(exp));
    endtask

    // levels right after reset.
    task automatic check_idle();
        check_level("geiger_mode_en", geiger_mode_en, 1'b1);
        check_level("quench_voltage_down", quench_voltage_down, 1'b0);
        check_level("reset_discharge", reset_discharge, 1'b0);
        check_level("led", led, 1'b0);
        check_level("tx_pin", tx_pin, 1'b1);   // uart idle.
    endtask

    task automatic expect_led(input logic exp);
        check_level("led", led, exp);
    endtask

    // end of one phase. frame against the decimal model.
    task automatic finish_test(input string name, input int unsigned exp_count,
                               input int unsigned exp_events);
        count_bcd_t  exp_bcd;
        int unsigned rest;
        rest = exp_count;
        for (int i = 0; i < count_digits; i++)
        begin
            exp_bcd[4*i +: 4] = bcd_digit_t'(rest % 10);   // lsd first.
            rest              = rest / 10;
        end
        if (frames_seen == frames_at_start)
            plain_error("no complete uart frame arrived in this test");
        else if (last_frame !== exp_bcd)
            value_error("tx_pin frame", last_frame, exp_bcd);
        if (events != exp_events)
            value_error("dead_time_count", events, exp_events);
        tests_run++;
        if (error_count == errors_at_start)
            $display("test %s: pass", name);
        else
        begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
        errors_at_start = error_count;
        frames_at_start = frames_seen;
        events          = 0;
    endtask

    task automatic print_summary();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, error_count);
    endtask

    ////////////////////
    // sample history, all taken at the falling edge.
    always @(negedge clk)
    begin
        pulse_hist <= {pulse_hist[3:0], signal_pulse};
        if (rst_n)
            sample_cnt <= sample_cnt + 1;
    end

    // quench, then recharge, geiger off for both.
    initial
    begin : dead_time_chk
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge clk);
            if (geiger_mode_en === 1'b0)
            begin
                events++;
                // two sync flops, edge reg, fsm reg.
                if (!(pulse_hist[3] && !pulse_hist[4]))
                    plain_error("geiger mode dropped without a detector edge 4 cycles before");
                for (int i = 0; i < dead_cycles; i++)
                begin
                    if (i > 0)
                        @(negedge clk);
                    check_level("geiger_mode_en", geiger_mode_en, 1'b0);
                    check_level("quench_voltage_down", quench_voltage_down, i < quench_cycles);
                    check_level("reset_discharge", reset_discharge, i >= quench_cycles);
                end
                @(negedge clk);
                check_level("geiger_mode_en", geiger_mode_en, 1'b1);   // re-armed.
            end
            check_level("quench_voltage_down", quench_voltage_down, 1'b0);
            check_level("reset_discharge", reset_discharge, 1'b0);
        end
    end

    ////////////////////
    // uart receive.
    // rest of one bit. every sample must match the first.
    task automatic read_bit(input int taken, inout logic level, output bit steady);
        steady = 1'b1;
        for (int i = taken; i < baud_div; i++)
        begin
            @(negedge clk);
            if (i == 0)
                level = tx_pin;
            else if (tx_pin !== level)
                steady = 1'b0;          // bit too short.
        end
    endtask

    initial
    begin : uart_rx
        logic       level;
        bit         steady;
        bit         good;
        ascii_t     rx_byte;
        int         byte_pos;
        int         last_start;
        count_bcd_t frame;
        byte_pos   = 0;
        last_start = -1;
        frame      = '0;
        rx_byte    = '0;
        wait (rst_n === 1'b1);
        forever
        begin
            @(negedge clk);
            if (tx_pin === 1'b0)
            begin
                if (byte_pos == 0)
                begin
                    // frame start. fixed report spacing.
                    if (last_start < 0 && sample_cnt < report_cycles)
                        plain_error("tx_pin left the idle level before the first report");
                    else if (last_start >= 0 && sample_cnt - last_start != report_cycles)
                        value_error("frame_interval", 32'(sample_cnt - last_start),
                                    32'(report_cycles));
                    last_start = sample_cnt;
                end
                level = 1'b0;
                read_bit(1, level, steady);     // start, one sample taken.
                good = steady;
                for (int b = 0; b < 8; b++)
                begin
                    read_bit(0, level, steady); // lsb first.
                    rx_byte[b] = level;
                    good       = good && steady;
                end
                read_bit(0, level, steady);
                good = good && steady && (level === 1'b1);
                if (!good)
                begin
                    plain_error($sformatf("tx_pin byte %0d has bad start, data or stop bits",
                                          byte_pos));
                    byte_pos = 0;
                end
                else if (byte_pos < count_digits)
                begin
                    if (rx_byte < ascii_zero || rx_byte > ascii_zero + 8'd9)
                    begin
                        $display("[ERROR] tx_pin byte %0d: got %h expected 30 to 39",
                                 byte_pos, rx_byte);
                        error_count++;
                    end
                    frame    = {frame[$bits(count_bcd_t)-5:0], bcd_digit_t'(rx_byte - ascii_zero)};
                    byte_pos = byte_pos + 1;
                end
                else if (byte_pos == count_digits)
                begin
                    if (rx_byte !== ascii_cr)
                        value_error("tx_pin cr byte", 32'(rx_byte), 32'(ascii_cr));
                    byte_pos = byte_pos + 1;
                end
                else
                begin
                    if (rx_byte !== ascii_lf)
                        value_error("tx_pin lf byte", 32'(rx_byte), 32'(ascii_lf));
                    last_frame = frame;             // frame complete.
                    frames_seen++;
                    byte_pos = 0;
                end
            end
        end
    end

endmodule

/* tb/tb_photon_counter_top.sv */
`timescale 1ns/10ps

module tb_photon_counter_top
    import photon_pkg::*;
();

    localparam int          clk_period      = 8;
    localparam int          dead_cycles     = quench_cycles + recharge_cycles;
    localparam int          gap_min         = dead_cycles + 4;  // dead time plus sync margin.
    localparam int          quiet_cycles    = 2 * report_cycles;
    localparam int          test_count      = 6;
    // each stimulus stays under one report interval.
    localparam int          watchdog_cycles = test_count * (report_cycles + quiet_cycles)
                                              + report_cycles;
    localparam logic [31:0] rand_seed       = 32'hf6d5_8414;

    logic        clk;
    logic        rst_n;
    logic        signal_pulse;
    logic        key_pin;
    logic        geiger_mode_en;
    logic        quench_voltage_down;
    logic        reset_discharge;
    logic        led;
    logic        tx_pin;
    int unsigned exp_count;     // model of the decimal count.
    int unsigned exp_events;    // accepted pulses in this phase.

    photon_counter_top u_photon_counter_top (
        .clk                 (clk),
        .rst_n               (rst_n),
        .signal_pulse        (signal_pulse),
        .key_pin             (key_pin),
        .geiger_mode_en      (geiger_mode_en),
        .quench_voltage_down (quench_voltage_down),
        .reset_discharge     (reset_discharge),
        .led                 (led),
        .tx_pin              (tx_pin)
    );

    photon_checker u_checker (
        .clk                 (clk),
        .rst_n               (rst_n),
        .signal_pulse        (signal_pulse),
        .geiger_mode_en      (geiger_mode_en),
        .quench_voltage_down (quench_voltage_down),
        .reset_discharge     (reset_discharge),
        .led                 (led),
        .tx_pin              (tx_pin)
    );

    ////////////////////
    // clock and watchdog.
    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    // n rising edges, then the drive delay.
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic drive_pulse(input int high_cycles, input int low_cycles);
        signal_pulse = 1'b1;
        tick(high_cycles);
        signal_pulse = 1'b0;
        tick(low_cycles);
    endtask

    task automatic quiet_and_check(input string name);
        tick(quiet_cycles);     // room for one full frame.
        u_checker.finish_test(name, exp_count, exp_events);
        exp_events = 0;
    endtask

    ////////////////////
    // test sequence.
    initial
    begin
        void'($urandom(rand_seed));
        rst_n        = 1'b0;
        signal_pulse = 1'b0;
        key_pin      = 1'b1;    // released.
        exp_count    = 0;
        exp_events   = 0;
        tick(2);
        rst_n = 1'b1;
        tick(1);
        u_checker.check_idle();
        quiet_and_check("reset");

        repeat (16)
        begin
            drive_pulse(1 + $urandom % 3, gap_min + $urandom % 16);
            exp_count++;
            exp_events++;
        end
        quiet_and_check("spaced");

        repeat (8)
        begin
            drive_pulse(1, 1);                      // accepted edge.
            drive_pulse(1 + $urandom % 2, 1);       // lands in quench.
            drive_pulse(1 + $urandom % 2, gap_min + $urandom % 8);
            exp_count++;
            exp_events++;
        end
        drive_pulse(dead_cycles + 6, gap_min);      // held across re-arm.
        exp_count++;
        exp_events++;
        quiet_and_check("burst");

        repeat (6)
        begin
            key_pin = 1'b0;
            tick(1 + $urandom % (debounce_cycles - 4));    // short bounce.
            key_pin = 1'b1;
            tick(2 + $urandom % 6);
            u_checker.expect_led(1'b0);
        end
        quiet_and_check("bounce");

        key_pin = 1'b0;
        tick(debounce_cycles + 8);
        u_checker.expect_led(1'b1);                 // lit while held.
        key_pin = 1'b1;
        tick(debounce_cycles + 8);
        u_checker.expect_led(1'b0);
        exp_count = 0;
        quiet_and_check("press");

        repeat (5)
        begin
            drive_pulse(1 + $urandom % 3, gap_min + $urandom % 16);
            exp_count++;
            exp_events++;
        end
        quiet_and_check("resume");

        u_checker.print_summary();
        if (u_checker.error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* photon_counter_top.f */
rtl/photon_pkg.sv
rtl/pulse_quench_ctrl.sv
rtl/bcd_event_counter.sv
rtl/key_debounce.sv
rtl/uart_count_report.sv
rtl/photon_counter_top.sv
tb/photon_checker.sv
tb/tb_photon_counter_top.sv

/* run_sim.sh */
#!/bin/sh
# build the photon counter testbench with verilator and run it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f photon_counter_top.f \
    --top-module tb_photon_counter_top \
    -Mdir obj_dir

# a crash or fatal assertion leaves no pass line.
sim_out=$(./obj_dir/Vtb_photon_counter_top || true)
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1
